/* src/coinCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module coinCounter (
	input  wire logic           clk24M,
	input  wire logic           arstN,
	input  wire neoIoPkg::ioSel sel,
	output logic [1:0]          counter,
	output logic [1:0]          lockout
);

	import neoIoPkg::*;

	logic coinWr;
	logic level;

	// Function codes 6 and 7, i.e. A6 and A5 both set
	assign coinWr = sel.wrLo & (sel.zone == zStatB) & (sel.fn[2:1] == 2'b11);

	// A4 picks set or reset, the data byte is ignored
	assign level = sel.sub[3];

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			counter <= '0;
			lockout <= '0;
		end else if (coinWr) begin
			// A2 and A1 pick the target
			case (sel.sub[1:0])
				2'd0: begin
					counter[0] <= level;
				end
				2'd1: begin
					counter[1] <= level;
				end
				2'd2: begin
					lockout[0] <= level;
				end
				default: begin
					lockout[1] <= level;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/inputPorts.sv */
`timescale 1ns/1ps
`default_nettype none

module inputPorts (
	input  wire logic            clk24M,
	input  wire logic            arstN,
	input  wire neoIoPkg::ioSel  sel,
	input  wire neoIoPkg::ioInputs inputs,
	output logic [15:0]          rdData
);

	import neoIoPkg::*;

	logic [7:0]  statusB;
	logic [7:0]  p1Lo;
	logic [15:0] rdWord;

	// STATUS_B, test button down to card detect
	assign statusB = {
		inputs.testBtn,
		boardMvs,
		inputs.p2In[9:8],
		inputs.p1In[9:8],
		inputs.cardDet
	};

	// Lower byte at 0x30 splits on A7
	// DIP switches below, test button alone above
	assign p1Lo = sel.a7 ? {inputs.testBtn, 7'h7F} : inputs.dipSw;

	// Word per zone, upper byte first
	always_comb begin
		case (sel.zone)
			zP1: begin
				rdWord = {inputs.p1In[7:0], p1Lo};
			end
			zSound: begin
				rdWord = {inputs.soundReply, inputs.coinIn};
			end
			zP2: begin
				rdWord = {inputs.p2In[7:0], 8'hFF};
			end
			zStatB: begin
				rdWord = {statusB, 8'hFF};
			end
			// Latches and LSPC give nothing back here
			default: begin
				rdWord = 16'hFFFF;
			end
		endcase
	end

	// Captured on the edge that raises ack
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			rdData <= 16'hFFFF;
		end else if (sel.rd) begin
			rdData <= rdWord;
		end
	end

endmodule

`default_nettype wire

/* src/ioDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module ioDecode (
	input  wire logic           clk24M,
	input  wire logic           arstN,
	input  wire neoIoPkg::wbReq req,
	output neoIoPkg::ioSel      sel,
	output logic                ack
);

	import neoIoPkg::*;

	ioZone zoneDec;
	logic  xfer;

	// Cycle presented and not yet answered
	assign xfer = req.cyc & req.stb & ~ack;

	// Zone match on A23 to A17
	always_comb begin
		case (req.adr[22:16])
			zone30: begin
				zoneDec = zP1;
			end
			zone32: begin
				zoneDec = zSound;
			end
			// P2 mask is loose, 0x34 and 0x36 both hit
			zone34, zone34 | 7'h01: begin
				zoneDec = zP2;
			end
			zone38: begin
				zoneDec = zStatB;
			end
			zone3A: begin
				zoneDec = zSysLatch;
			end
			zone3C: begin
				zoneDec = zLspc;
			end
			default: begin
				zoneDec = zNone;
			end
		endcase
	end

	// Select bundle for the register blocks
	always_comb begin
		sel.zone  = zoneDec;
		// Read strobe, first cycle only
		sel.rd    = xfer & ~req.we;
		// Write strobe, lower byte lane only
		sel.wrLo  = xfer & req.we & req.sel[0];
		sel.sub   = req.adr[3:0];
		sel.fn    = req.adr[5:3];
		sel.a7    = req.adr[6];
		sel.datLo = req.dat[7:0];
	end

	// Single ack register
	// High for one cycle, then low again even if stb stays up
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			ack <= 1'b0;
		end else begin
			ack <= xfer;
		end
	end

endmodule

`default_nettype wire

/* src/neoIoPkg.sv */
`default_nettype none

package neoIoPkg;

	// Wishbone classic request, word wide
	// adr holds byte address bits 23 to 1
	// sel[1] is the upper byte at the even address, sel[0] the lower byte at the odd one
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [22:0] adr;
		logic [1:0]  sel;
		logic [15:0] dat;
	} wbReq;

	// Wishbone classic response
	typedef struct packed {
		logic [15:0] dat;
		logic        ack;
	} wbRsp;

	// Board inputs seen through the read ports
	typedef struct packed {
		logic [9:0] p1In;
		logic [9:0] p2In;
		logic [7:0] dipSw;
		logic       testBtn;
		// STATUS_A content
		logic [7:0] coinIn;
		logic [7:0] soundReply;
		logic [1:0] cardDet;
	} ioInputs;

	// Zones of the system I/O area
	typedef enum logic [2:0] {
		zP1,
		zSound,
		zP2,
		zStatB,
		zSysLatch,
		zLspc,
		zNone
	} ioZone;

	// Address bits 23 to 17 of each zone
	localparam logic [6:0] zone30 = 7'h18;
	localparam logic [6:0] zone32 = 7'h19;
	// P2 also answers at 0x1B
	localparam logic [6:0] zone34 = 7'h1A;
	localparam logic [6:0] zone38 = 7'h1C;
	localparam logic [6:0] zone3A = 7'h1D;
	localparam logic [6:0] zone3C = 7'h1E;

	// Decoded access handed to the register blocks
	typedef struct packed {
		ioZone      zone;
		logic       rd;
		// One-cycle strobe, lower byte write
		logic       wrLo;
		// Address bits 4 to 1
		logic [3:0] sub;
		// Address bits 6 to 4
		logic [2:0] fn;
		logic       a7;
		logic [7:0] datLo;
	} ioSel;

	// System latch flags, shadow in bit 0 up to palBnk in bit 7
	typedef struct packed {
		logic palBnk;
		logic nSramLock;
		logic nSystem;
		logic nRegEn;
		logic cardWenB;
		logic nCardWen;
		logic nVec;
		logic shadow;
	} sysFlags;

	// MVS board type bit in STATUS_B
	localparam logic boardMvs = 1'b1;

endpackage

`default_nettype wire

/* src/neoIoTop.sv */
`timescale 1ns/1ps
`default_nettype none

module neoIoTop #(
	// Cartridge slots on the board, 1, 2, 4 or 6
	parameter int slotCount = 6
) (
	input  wire logic              clk24M,
	input  wire logic              arstN,
	input  wire neoIoPkg::wbReq    req,
	output neoIoPkg::wbRsp         rsp,
	input  wire neoIoPkg::ioInputs inputs,
	output logic [2:0]             p1Out,
	output logic [2:0]             p2Out,
	output logic [2:0]             crdBank,
	output logic [5:0]             nSlot,
	output logic [2:0]             rtcCtrl,
	output logic [2:0]             elOut,
	output logic [7:0]             ledOut1,
	output logic [7:0]             ledOut2,
	output logic [1:0]             counter,
	output logic [1:0]             lockout,
	output neoIoPkg::sysFlags      flags
);

	import neoIoPkg::*;

	// Decoded access, shared by all register blocks
	ioSel ioSelBus;

	// Bus slave and zone decode
	ioDecode dec0 (
		.clk24M (clk24M),
		.arstN  (arstN),
		.req    (req),
		.sel    (ioSelBus),
		.ack    (rsp.ack)
	);

	// Read side
	inputPorts inp0 (
		.clk24M (clk24M),
		.arstN  (arstN),
		.sel    (ioSelBus),
		.inputs (inputs),
		.rdData (rsp.dat)
	);

	// 0x38 write registers
	outputLatches #(
		.slotCount (slotCount)
	) outl0 (
		.clk24M  (clk24M),
		.arstN   (arstN),
		.sel     (ioSelBus),
		.p1Out   (p1Out),
		.p2Out   (p2Out),
		.crdBank (crdBank),
		.nSlot   (nSlot),
		.rtcCtrl (rtcCtrl),
		.elOut   (elOut),
		.ledOut1 (ledOut1),
		.ledOut2 (ledOut2)
	);

	// Coin counters and lockouts
	coinCounter coin0 (
		.clk24M  (clk24M),
		.arstN   (arstN),
		.sel     (ioSelBus),
		.counter (counter),
		.lockout (lockout)
	);

	// 0x3A flags
	systemLatch sysl0 (
		.clk24M (clk24M),
		.arstN  (arstN),
		.sel    (ioSelBus),
		.flags  (flags)
	);

endmodule

`default_nettype wire

/* src/outputLatches.sv */
`timescale 1ns/1ps
`default_nettype none

module outputLatches #(
	parameter int slotCount = 6
) (
	input  wire logic           clk24M,
	input  wire logic           arstN,
	input  wire neoIoPkg::ioSel sel,
	output logic [2:0]          p1Out,
	output logic [2:0]          p2Out,
	output logic [2:0]          crdBank,
	output logic [5:0]          nSlot,
	output logic [2:0]          rtcCtrl,
	output logic [2:0]          elOut,
	output logic [7:0]          ledOut1,
	output logic [7:0]          ledOut2
);

	import neoIoPkg::*;

	logic       wr38;
	logic [2:0] ledLatch;
	logic [7:0] ledData;
	logic [2:0] ledRise;
	logic [2:0] slotIdx;

	// Lower byte write into the 0x38 zone
	assign wr38 = sel.wrLo & (sel.zone == zStatB);

	// Latch bits going from low to high in this write
	assign ledRise = sel.datLo[5:3] & ~ledLatch;

	// Slot number folded onto the slots fitted
	assign slotIdx = 3'(sel.datLo[2:0] % slotCount);

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			p1Out    <= '0;
			p2Out    <= '0;
			crdBank  <= '0;
			nSlot    <= 6'b111110;
			rtcCtrl  <= '0;
			ledLatch <= '0;
			ledData  <= '0;
			elOut    <= '0;
			ledOut1  <= '0;
			ledOut2  <= '0;
		end else if (wr38) begin
			case (sel.fn)
				// POUTPUT, both joypad output nibbles
				3'd0: begin
					p1Out <= sel.datLo[2:0];
					p2Out <= sel.datLo[5:3];
				end
				// CRDBANK
				3'd1: begin
					crdBank <= sel.datLo[2:0];
				end
				// SLOT, one low select line
				3'd2: begin
					nSlot <= ~(6'b000001 << slotIdx);
				end
				// LEDLATCHES, a rising bit clocks LEDDATA out
				3'd3: begin
					ledLatch <= sel.datLo[5:3];
					if (ledRise[0]) begin
						elOut <= ledData[2:0];
					end
					if (ledRise[1]) begin
						ledOut1 <= ledData;
					end
					if (ledRise[2]) begin
						ledOut2 <= ledData;
					end
				end
				// LEDDATA, held until a latch edge
				3'd4: begin
					ledData <= sel.datLo;
				end
				// RTCCTRL
				3'd5: begin
					rtcCtrl <= sel.datLo[2:0];
				end
				// Coin control lives in coinCounter
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/systemLatch.sv */
`timescale 1ns/1ps
`default_nettype none

module systemLatch (
	input  wire logic           clk24M,
	input  wire logic           arstN,
	input  wire neoIoPkg::ioSel sel,
	output neoIoPkg::sysFlags   flags
);

	import neoIoPkg::*;

	logic [7:0] flagBits;
	logic       latchWr;

	// Any lower byte write in the 0x3A zone
	assign latchWr = sel.wrLo & (sel.zone == zSysLatch);

	// Bit 0 lands on shadow, bit 7 on palBnk
	assign flags = flagBits;

	// Addressable latch
	// A3 to A1 pick the flag, A4 is the new value
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			flagBits <= '0;
		end else if (latchWr) begin
			flagBits[sel.sub[2:0]] <= sel.sub[3];
		end
	end

endmodule

`default_nettype wire

/* tests/neoIoModel.svh */
`ifndef NEO_IO_MODEL_SVH
`define NEO_IO_MODEL_SVH

// LCG state, fixed seed
logic [31:0] lcgState = 32'd72;

// Shadow of every write register
logic [2:0] shP1Out;
logic [2:0] shP2Out;
logic [2:0] shCrdBank;
logic [5:0] shNSlot;
logic [2:0] shRtcCtrl;
logic [2:0] shLedLatch;
logic [7:0] shLedData;
logic [2:0] shElOut;
logic [7:0] shLedOut1;
logic [7:0] shLedOut2;
logic [1:0] shCounter;
logic [1:0] shLockout;
logic [7:0] shFlags;

// Halves swapped so the weak low bits end up on top
function automatic logic [31:0] lcgNext();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return {lcgState[15:0], lcgState[31:16]};
endfunction

function automatic ioInputs randomInputs();
	logic [63:0] raw;
	raw = {lcgNext(), lcgNext()};
	return raw[46:0];
endfunction

// Expected read word for a board state and an address (A23 to A1)
function automatic logic [15:0] expectRead(input ioInputs bundle, input logic [22:0] adr);
	logic [7:0] statB;
	logic [7:0] lowP1;
	statB = {bundle.testBtn, 1'b1, bundle.p2In[9:8], bundle.p1In[9:8], bundle.cardDet};
	// A7 switches between DIP switches and test button
	lowP1 = adr[6] ? {bundle.testBtn, 7'h7F} : bundle.dipSw;
	case (adr[22:16])
		7'h18: return {bundle.p1In[7:0], lowP1};
		7'h19: return {bundle.soundReply, bundle.coinIn};
		7'h1A, 7'h1B: return {bundle.p2In[7:0], 8'hFF};
		7'h1C: return {statB, 8'hFF};
		default: return 16'hFFFF;
	endcase
endfunction

task automatic resetShadow();
	{shP1Out, shP2Out, shCrdBank, shRtcCtrl, shLedLatch, shElOut} = '0;
	{shLedData, shLedOut1, shLedOut2, shFlags} = '0;
	{shCounter, shLockout} = '0;
	// Slot 0 selected, active low
	shNSlot = 6'b111110;
endtask

// Same register map as the hardware, applied to the shadow
task automatic applyWrite(input logic [22:0] adr, input logic [1:0] bsel, input logic [15:0] dat);
	logic [2:0] rise;
	rise = dat[5:3] & ~shLedLatch;
	// Upper lane alone changes nothing
	if (bsel[0] && adr[22:16] == 7'h1D) begin
		shFlags[adr[2:0]] = adr[3];
	end else if (bsel[0] && adr[22:16] == 7'h1C) begin
		case (adr[5:3])
			3'd0: begin
				shP1Out = dat[2:0];
				shP2Out = dat[5:3];
			end
			3'd1: shCrdBank = dat[2:0];
			3'd2: shNSlot = ~(6'd1 << (dat[2:0] % tbSlots));
			3'd3: begin
				shLedLatch = dat[5:3];
				if (rise[0]) shElOut = shLedData[2:0];
				if (rise[1]) shLedOut1 = shLedData;
				if (rise[2]) shLedOut2 = shLedData;
			end
			3'd4: shLedData = dat[7:0];
			3'd5: shRtcCtrl = dat[2:0];
			// Coin codes, A4 is the level and A2 picks counter or lockout
			default: begin
				if (!adr[1]) shCounter[adr[0]] = adr[3];
				else shLockout[adr[0]] = adr[3];
			end
		endcase
	end
endtask

`endif

/* tests/neoIoTb.sv */
`timescale 1ns/1ps
`default_nettype none

module neoIoTb;

	import neoIoPkg::*;

	localparam int tbSlots = 4;
	// Transfers over all six tests
	localparam int totalXfers = 133;
	localparam int limitCycles = totalXfers * 4 + 10 + 100;

	// Transfer still waiting for its ack
	typedef struct packed {
		logic        we;
		logic [22:0] adr;
		logic [1:0]  bsel;
		logic [15:0] dat;
		logic [15:0] expRd;
	} xferRec;

	logic       clk24M = 1'b0;
	logic       arstN;
	wbReq       req;
	wbRsp       rsp;
	ioInputs    inputs;
	logic [2:0] p1Out;
	logic [2:0] p2Out;
	logic [2:0] crdBank;
	logic [5:0] nSlot;
	logic [2:0] rtcCtrl;
	logic [2:0] elOut;
	logic [7:0] ledOut1;
	logic [7:0] ledOut2;
	logic [1:0] counter;
	logic [1:0] lockout;
	sysFlags    flags;
	int         errCount = 0;
	int         checkCount = 0;
	int         ackCount = 0;
	int         lastWait;
	logic       prevAck = 1'b0;
	xferRec     pendQ[$];

	`include "neoIoModel.svh"

	neoIoTop #(
		.slotCount (tbSlots)
	) dut0 (
		.clk24M  (clk24M),
		.arstN   (arstN),
		.req     (req),
		.rsp     (rsp),
		.inputs  (inputs),
		.p1Out   (p1Out),
		.p2Out   (p2Out),
		.crdBank (crdBank),
		.nSlot   (nSlot),
		.rtcCtrl (rtcCtrl),
		.elOut   (elOut),
		.ledOut1 (ledOut1),
		.ledOut2 (ledOut2),
		.counter (counter),
		.lockout (lockout),
		.flags   (flags)
	);

	always #5 clk24M = ~clk24M;

	task automatic checkEq(input string name, input logic [15:0] expVal, input logic [15:0] actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errCount++;
			$display("ERROR %0t %s expected %h actual %h", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkOutputs();
		checkEq("p1Out", shP1Out, p1Out);
		checkEq("p2Out", shP2Out, p2Out);
		checkEq("crdBank", shCrdBank, crdBank);
		checkEq("nSlot", shNSlot, nSlot);
		checkEq("rtcCtrl", shRtcCtrl, rtcCtrl);
		checkEq("elOut", shElOut, elOut);
		checkEq("ledOut1", shLedOut1, ledOut1);
		checkEq("ledOut2", shLedOut2, ledOut2);
		checkEq("counter", shCounter, counter);
		checkEq("lockout", shLockout, lockout);
		checkEq("flags", shFlags, flags);
	endtask

	function automatic logic [22:0] makeAdr(input logic [6:0] zone, input logic [2:0] fn);
		logic [31:0] r;
		r = lcgNext();
		return {zone, r[12:3], fn, r[2:0]};
	endfunction

	// Called 1 ns after an edge and returns 1 ns after the ack edge with stb still high
	task automatic busXfer(input logic we, input logic [22:0] adr, input logic [1:0] bsel,
		input logic [15:0] dat);
		xferRec rec;
		rec = {we, adr, bsel, dat, expectRead(inputs, adr)};
		req = {1'b1, 1'b1, we, adr, bsel, dat};
		pendQ.push_back(rec);
		lastWait = 0;
		do begin
			@(posedge clk24M);
			#1;
			lastWait++;
		end while (!rsp.ack && lastWait < 8);
		if (!rsp.ack) begin
			errCount++;
			$display("No acknowledge from the DUT for address %h at %0t", adr, $time);
		end
	endtask

	task automatic idleBus();
		req.cyc = 1'b0;
		req.stb = 1'b0;
		@(posedge clk24M);
		#1;
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		$display("Test %0d %s finished with %0d errors", num, name, errCount - errBefore);
	endtask

	// Compare process runs mid cycle so the ack edge has settled
	always @(negedge clk24M) begin
		xferRec rec;
		if (rsp.ack) begin
			ackCount++;
			if (prevAck) begin
				errCount++;
				$display("Acknowledge stayed high for two cycles at %0t", $time);
			end
			if (pendQ.size() == 0) begin
				errCount++;
				$display("Acknowledge at %0t with no transfer pending", $time);
			end else begin
				rec = pendQ.pop_front();
				if (rec.we) begin
					applyWrite(rec.adr, rec.bsel, rec.dat);
					checkOutputs();
				end else begin
					checkEq("rsp.dat", rec.expRd, rsp.dat);
				end
			end
		end
		prevAck = rsp.ack;
	end

	// Watchdog
	initial begin
		#(limitCycles * 10);
		$display("Timeout, the tests did not finish within %0d cycles", limitCycles);
		$display("Errors found");
		$finish;
	end

	initial begin
		int          e0;
		int          a0;
		logic [31:0] r;
		logic [15:0] dat;
		logic [1:0]  bsel;
		logic [22:0] adr;
		logic [6:0]  zoneList [10];
		logic [2:0]  fnList [5];
		logic [2:0]  latchSeq [8];
		// Mapped, mirrored and unmapped zones
		zoneList = '{7'h18, 7'h19, 7'h1A, 7'h1B, 7'h1C, 7'h1D, 7'h1E, 7'h1F, 7'h00, 7'h7F};
		fnList = '{3'd0, 3'd1, 3'd2, 3'd5, 3'd2};
		// Bits 3 to 5 of each LEDLATCHES write with and without rising bits
		latchSeq = '{3'd0, 3'd1, 3'd3, 3'd3, 3'd0, 3'd7, 3'd4, 3'd6};
		req = '0;
		inputs = '0;
		arstN = 1'b0;
		resetShadow();
		repeat (10) @(posedge clk24M);
		#1 arstN = 1'b1;
		@(posedge clk24M);
		#1;

		e0 = errCount;
		checkOutputs();
		checkEq("rsp.ack", 16'd0, rsp.ack);
		// Read register comes out of reset as all ones
		checkEq("rsp.dat", 16'hFFFF, rsp.dat);
		inputs = randomInputs();
		busXfer(1'b0, {7'h1C, 16'h0000}, 2'b11, 16'h0000);
		checkEq("ackLatency", 16'd1, lastWait);
		idleBus();
		reportTest(1, "reset state", e0);

		e0 = errCount;
		for (int i = 0; i < 40; i++) begin
			inputs = randomInputs();
			adr = {zoneList[i % 10], 16'(lcgNext())};
			// Both A7 halves at every zone
			adr[6] = i[3];
			busXfer(1'b0, adr, 2'b11, 16'(lcgNext()));
		end
		idleBus();
		reportTest(2, "reads", e0);

		e0 = errCount;
		for (int i = 0; i < 24; i++) begin
			r = lcgNext();
			dat = r[15:0];
			bsel = {r[16], 1'b1};
			// Slot values 4 to 7 wrap
			if (i % 6 == 4) dat[2] = 1'b1;
			// Upper lane only into a different register each round
			if (i % 6 == 5) bsel = 2'b10;
			busXfer(1'b1, makeAdr(7'h1C, fnList[(i % 6 == 5) ? i / 6 : i % 6]), bsel, dat);
		end
		idleBus();
		reportTest(3, "write latches", e0);

		e0 = errCount;
		for (int i = 0; i < 8; i++) begin
			busXfer(1'b1, makeAdr(7'h1C, 3'd4), 2'b01, 16'(lcgNext()));
			r = lcgNext();
			busXfer(1'b1, makeAdr(7'h1C, 3'd3), 2'b01, {r[15:6], latchSeq[i], r[2:0]});
		end
		idleBus();
		reportTest(4, "LED path", e0);

		e0 = errCount;
		// Every target is set first and cleared after
		for (int i = 0; i < 16; i++) begin
			busXfer(1'b1, {7'h1C, 10'(lcgNext()), 2'b11, 4'(i ^ 8)}, 2'b11, 16'(lcgNext()));
		end
		for (int i = 0; i < 16; i++) begin
			busXfer(1'b1, {7'h1D, 12'(lcgNext()), 4'(i ^ 8)}, 2'b11, 16'(lcgNext()));
		end
		idleBus();
		reportTest(5, "coin control and system latch", e0);

		e0 = errCount;
		a0 = ackCount;
		for (int i = 0; i < 20; i++) begin
			r = lcgNext();
			if (i % 2 == 0) begin
				inputs = randomInputs();
				busXfer(1'b0, {zoneList[r % 10], 16'(lcgNext())}, 2'b11, r[15:0]);
			end else begin
				adr = makeAdr(r[20] ? 7'h1D : 7'h1C, r[19:17]);
				busXfer(1'b1, adr, 2'b01, r[15:0]);
			end
			// Two cycles per transfer while stb stays high
			if (i > 0) checkEq("ackSpacing", 16'd2, lastWait);
		end
		idleBus();
		checkEq("ackCount", 16'd20, 16'(ackCount - a0));
		checkOutputs();
		reportTest(6, "back-to-back transfers", e0);

		repeat (2) @(posedge clk24M);
		$display("Checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
src/neoIoPkg.sv
src/ioDecode.sv
src/inputPorts.sv
src/outputLatches.sv
src/coinCounter.sv
src/systemLatch.sv
src/neoIoTop.sv
tests/neoIoTb.sv
